// File: common/isaPkg.sv
package isaPkg;

    typedef logic [15:0] wordT;
    typedef logic [1:0]  regIdxT;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcodeT;

    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funcT;

    // low codes line up with the R-type function codes
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_ORR   = 4'd3,
        ALU_NOT   = 4'd4,
        ALU_TCP   = 4'd5,
        ALU_SHL   = 4'd6,
        ALU_SHR   = 4'd7,
        ALU_PASSB = 4'd8
    } aluOpT;

    typedef struct packed {
        opcodeT opcode;
        regIdxT rs;
        regIdxT rt;
        regIdxT rd;
        funcT   func;
    } rTypeT;

    typedef struct packed {
        opcodeT     opcode;
        regIdxT     rs;
        regIdxT     rt;
        logic [7:0] imm8;
    } iTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [11:0] target12;
    } jTypeT;

endpackage

// File: common/pipePkg.sv
package pipePkg;

    typedef struct packed {
        logic           regWrite;
        logic           memRead;
        logic           memWrite;
        logic           useImm;
        logic           isBranch;
        logic           isWwd;
        logic           isHalt;
        isaPkg::aluOpT  aluOp;
        isaPkg::regIdxT dest;
    } ctrlT;

    typedef struct packed {
        isaPkg::wordT inst;
        isaPkg::wordT pcPlus1;
    } ifIdT;

    typedef struct packed {
        ctrlT           ctrl;
        isaPkg::wordT   rsData;
        isaPkg::wordT   rtData;
        isaPkg::regIdxT rs;
        isaPkg::regIdxT rt;
        isaPkg::wordT   imm;
        isaPkg::opcodeT opcode;
        isaPkg::wordT   pcPlus1;
    } idExT;

    typedef struct packed {
        ctrlT         ctrl;
        isaPkg::wordT aluResult;
        isaPkg::wordT storeData;
    } exMemT;

    typedef struct packed {
        ctrlT         ctrl;
        isaPkg::wordT aluResult;
        isaPkg::wordT loadData;
    } memWbT;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_MEM = 2'd1,
        FWD_WB  = 2'd2
    } fwdSelT;

endpackage

// File: core/pipeStage.sv
`timescale 1ns/100ps

module pipeStage #(
    parameter type payloadT = logic [15:0]
) (
    input  logic    Clk,
    input  logic    reset,
    input  logic    hold,
    input  logic    bubble,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // a bubble wins over hold, so a flush never leaves a stale valid behind
    always_ff @(posedge Clk) begin
        if (reset || bubble) begin
            outValid <= 1'b0;
            outData  <= '0;
        end else if (!hold) begin
            outValid <= inValid;
            outData  <= inData;
        end
    end

endmodule

// File: core/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic           Clk,
    input  logic           reset,
    input  isaPkg::regIdxT readA,
    input  isaPkg::regIdxT readB,
    input  isaPkg::regIdxT writeIdx,
    input  isaPkg::wordT   writeData,
    input  logic           writeEn,
    output isaPkg::wordT   dataA,
    output isaPkg::wordT   dataB
);

    isaPkg::wordT regs [4];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeIdx] <= writeData;
        end
    end

    // write-through so ID sees the value WB is writing this cycle
    assign dataA = (writeEn && writeIdx == readA) ? writeData : regs[readA];
    assign dataB = (writeEn && writeIdx == readB) ? writeData : regs[readB];

endmodule

// File: core/alu.sv
`timescale 1ns/100ps

module alu (
    input  isaPkg::wordT   a,
    input  isaPkg::wordT   b,
    input  isaPkg::aluOpT  op,
    input  isaPkg::opcodeT opcode,
    output isaPkg::wordT   result,
    output logic           branchTaken
);

    always_comb begin
        case (op)
            isaPkg::ALU_ADD: result = a + b;
            isaPkg::ALU_SUB: result = a - b;
            isaPkg::ALU_AND: result = a & b;
            isaPkg::ALU_ORR: result = a | b;
            isaPkg::ALU_NOT: result = ~a;
            isaPkg::ALU_TCP: result = ~a + 16'd1;
            isaPkg::ALU_SHL: result = a << 1;
            isaPkg::ALU_SHR: result = $signed(a) >>> 1;
            default:         result = b;
        endcase
    end

    // BGZ and BLZ look at rs alone, as signed
    always_comb begin
        case (opcode)
            isaPkg::OP_BNE: branchTaken = a != b;
            isaPkg::OP_BEQ: branchTaken = a == b;
            isaPkg::OP_BGZ: branchTaken = $signed(a) > 16'sd0;
            isaPkg::OP_BLZ: branchTaken = $signed(a) < 16'sd0;
            default:        branchTaken = 1'b0;
        endcase
    end

endmodule

// File: core/pipelineControl.sv
`timescale 1ns/100ps

module pipelineControl (
    input  logic            Clk,
    input  logic            reset,
    input  isaPkg::wordT    idInst,
    input  logic            idValid,
    input  pipePkg::idExT   exStage,
    input  logic            exValid,
    input  pipePkg::exMemT  memStage,
    input  logic            memValid,
    input  pipePkg::memWbT  wbStage,
    input  logic            wbValid,
    input  logic            branchTaken,
    output pipePkg::ctrlT   idCtrl,
    output logic            stallFetch,
    output logic            bubbleEx,
    output logic            flushIfId,
    output logic            flushIdEx,
    output logic            jumpTaken,
    output pipePkg::fwdSelT fwdA,
    output pipePkg::fwdSelT fwdB
);

    isaPkg::rTypeT rInst;
    logic          useRs;
    logic          useRt;
    logic          isJump;
    logic          loadUse;
    logic          branchFlush;
    logic          haltInId;
    logic          haltSeen;

    function automatic pipePkg::fwdSelT pickFwd(input isaPkg::regIdxT src);
        if (memValid && memStage.ctrl.regWrite && memStage.ctrl.dest == src) begin
            return pipePkg::FWD_MEM;
        end
        if (wbValid && wbStage.ctrl.regWrite && wbStage.ctrl.dest == src) begin
            return pipePkg::FWD_WB;
        end
        return pipePkg::FWD_REG;
    endfunction

    assign rInst = isaPkg::rTypeT'(idInst);

    always_comb begin
        idCtrl = '0;
        useRs  = 1'b0;
        useRt  = 1'b0;
        isJump = 1'b0;
        case (rInst.opcode)
            isaPkg::OP_BNE, isaPkg::OP_BEQ, isaPkg::OP_BGZ, isaPkg::OP_BLZ: begin
                idCtrl.isBranch = 1'b1;
                idCtrl.aluOp    = isaPkg::ALU_SUB;
                useRs           = 1'b1;
                useRt           = rInst.opcode inside {isaPkg::OP_BNE, isaPkg::OP_BEQ};
            end
            isaPkg::OP_ADI, isaPkg::OP_ORI, isaPkg::OP_LHI, isaPkg::OP_LWD: begin
                idCtrl.regWrite = 1'b1;
                idCtrl.useImm   = 1'b1;
                idCtrl.memRead  = rInst.opcode == isaPkg::OP_LWD;
                idCtrl.dest     = rInst.rt;
                useRs           = rInst.opcode != isaPkg::OP_LHI;
                if (rInst.opcode == isaPkg::OP_ORI) begin
                    idCtrl.aluOp = isaPkg::ALU_ORR;
                end else if (rInst.opcode == isaPkg::OP_LHI) begin
                    idCtrl.aluOp = isaPkg::ALU_PASSB;
                end else begin
                    idCtrl.aluOp = isaPkg::ALU_ADD;
                end
            end
            isaPkg::OP_SWD: begin
                idCtrl.memWrite = 1'b1;
                idCtrl.useImm   = 1'b1;
                idCtrl.aluOp    = isaPkg::ALU_ADD;
                useRs           = 1'b1;
                useRt           = 1'b1;
            end
            isaPkg::OP_JMP: begin
                isJump = 1'b1;
            end
            isaPkg::OP_RTYPE: begin
                if (rInst.func <= isaPkg::FN_SHR) begin
                    idCtrl.regWrite = 1'b1;
                    idCtrl.aluOp    = isaPkg::aluOpT'(idInst[3:0]);
                    idCtrl.dest     = rInst.rd;
                    useRs           = 1'b1;
                    useRt           = rInst.func <= isaPkg::FN_ORR;
                end else if (rInst.func == isaPkg::FN_WWD) begin
                    // rs plus a zero immediate carries the value to WB
                    idCtrl.isWwd  = 1'b1;
                    idCtrl.useImm = 1'b1;
                    idCtrl.aluOp  = isaPkg::ALU_ADD;
                    useRs         = 1'b1;
                end else if (rInst.func == isaPkg::FN_HLT) begin
                    idCtrl.isHalt = 1'b1;
                end
            end
            default: begin
                idCtrl = '0;
            end
        endcase
    end

    assign branchFlush = exValid && exStage.ctrl.isBranch && branchTaken;
    assign loadUse     = idValid && exValid && exStage.ctrl.memRead &&
                         ((useRs && exStage.ctrl.dest == rInst.rs) ||
                          (useRt && exStage.ctrl.dest == rInst.rt));
    assign haltInId    = idValid && idCtrl.isHalt;

    assign stallFetch = loadUse;
    assign bubbleEx   = loadUse;
    assign jumpTaken  = idValid && isJump && !branchFlush;
    assign flushIdEx  = branchFlush;
    // nothing younger than a decoded HLT may enter the pipe
    assign flushIfId  = branchFlush || jumpTaken || haltInId || haltSeen;

    always_comb begin
        fwdA = pickFwd(exStage.rs);
        fwdB = pickFwd(exStage.rt);
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            haltSeen <= 1'b0;
        end else if (haltInId && !branchFlush) begin
            haltSeen <= 1'b1;
        end
    end

endmodule

// File: core/datapath.sv
`timescale 1ns/100ps

module datapath #(
    parameter isaPkg::wordT ResetPc = '0
) (
    input  logic            Clk,
    input  logic            reset,
    output isaPkg::wordT    instAddr,
    input  isaPkg::wordT    instData,
    output isaPkg::wordT    dataAddr,
    output isaPkg::wordT    dataWdata,
    input  isaPkg::wordT    dataRdata,
    output logic            dataRead,
    output logic            dataWrite,
    output isaPkg::wordT    outputPort,
    output logic            outputValid,
    output isaPkg::wordT    instCount,
    output logic            halted,
    output pipePkg::ifIdT   ifIdIn,
    output logic            fetchValid,
    input  pipePkg::ifIdT   ifIdQ,
    output pipePkg::idExT   idExIn,
    input  pipePkg::idExT   idExQ,
    output pipePkg::exMemT  exMemIn,
    input  pipePkg::exMemT  exMemQ,
    input  logic            exMemValid,
    output pipePkg::memWbT  memWbIn,
    input  pipePkg::memWbT  memWbQ,
    input  logic            memWbValid,
    input  pipePkg::ctrlT   idCtrl,
    input  logic            stallFetch,
    input  logic            flushIdEx,
    input  logic            jumpTaken,
    input  pipePkg::fwdSelT fwdA,
    input  pipePkg::fwdSelT fwdB,
    output isaPkg::wordT    aluA,
    output isaPkg::wordT    aluB,
    output isaPkg::aluOpT   aluOp,
    output isaPkg::opcodeT  aluOpcode,
    input  isaPkg::wordT    aluResult,
    output isaPkg::regIdxT  regReadA,
    output isaPkg::regIdxT  regReadB,
    input  isaPkg::wordT    regDataA,
    input  isaPkg::wordT    regDataB,
    output isaPkg::regIdxT  regWriteIdx,
    output isaPkg::wordT    regWriteData,
    output logic            regWriteEn
);

    isaPkg::wordT  pc;
    isaPkg::wordT  pcPlus1;
    isaPkg::wordT  nextPc;
    isaPkg::wordT  extImm;
    isaPkg::wordT  fwdDataA;
    isaPkg::wordT  fwdDataB;
    isaPkg::wordT  wbValue;
    isaPkg::iTypeT idFields;
    isaPkg::jTypeT jumpFields;
    logic          retire;

    // fetch
    assign pcPlus1    = pc + 16'd1;
    assign instAddr   = pc;
    assign fetchValid = !halted;
    assign ifIdIn     = '{inst: instData, pcPlus1: pcPlus1};

    assign idFields   = isaPkg::iTypeT'(ifIdQ.inst);
    assign jumpFields = isaPkg::jTypeT'(ifIdQ.inst);

    // a taken branch in EX is older than a JMP in ID
    always_comb begin
        if (stallFetch || halted) begin
            nextPc = pc;
        end else if (flushIdEx) begin
            nextPc = idExQ.pcPlus1 + idExQ.imm;
        end else if (jumpTaken) begin
            nextPc = {ifIdQ.pcPlus1[15:12], jumpFields.target12};
        end else begin
            nextPc = pcPlus1;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc <= ResetPc;
        end else begin
            pc <= nextPc;
        end
    end

    // decode
    always_comb begin
        case (idFields.opcode)
            isaPkg::OP_ORI:   extImm = {8'd0, idFields.imm8};
            isaPkg::OP_LHI:   extImm = {idFields.imm8, 8'd0};
            isaPkg::OP_RTYPE: extImm = '0;
            default:          extImm = {{8{idFields.imm8[7]}}, idFields.imm8};
        endcase
    end

    assign regReadA = idFields.rs;
    assign regReadB = idFields.rt;

    always_comb begin
        idExIn.ctrl    = idCtrl;
        idExIn.rsData  = regDataA;
        idExIn.rtData  = regDataB;
        idExIn.rs      = idFields.rs;
        idExIn.rt      = idFields.rt;
        idExIn.imm     = extImm;
        idExIn.opcode  = idFields.opcode;
        idExIn.pcPlus1 = ifIdQ.pcPlus1;
    end

    // execute
    always_comb begin
        case (fwdA)
            pipePkg::FWD_MEM: fwdDataA = exMemQ.aluResult;
            pipePkg::FWD_WB:  fwdDataA = wbValue;
            default:          fwdDataA = idExQ.rsData;
        endcase
        case (fwdB)
            pipePkg::FWD_MEM: fwdDataB = exMemQ.aluResult;
            pipePkg::FWD_WB:  fwdDataB = wbValue;
            default:          fwdDataB = idExQ.rtData;
        endcase
    end

    assign aluA      = fwdDataA;
    assign aluB      = idExQ.ctrl.useImm ? idExQ.imm : fwdDataB;
    assign aluOp     = idExQ.ctrl.aluOp;
    assign aluOpcode = idExQ.opcode;
    assign exMemIn   = '{ctrl: idExQ.ctrl, aluResult: aluResult, storeData: fwdDataB};

    // memory
    assign dataAddr  = exMemQ.aluResult;
    assign dataWdata = exMemQ.storeData;
    assign dataRead  = exMemValid && exMemQ.ctrl.memRead && !halted;
    assign dataWrite = exMemValid && exMemQ.ctrl.memWrite && !halted;
    assign memWbIn   = '{ctrl: exMemQ.ctrl, aluResult: exMemQ.aluResult, loadData: dataRdata};

    // writeback and retirement
    assign wbValue      = memWbQ.ctrl.memRead ? memWbQ.loadData : memWbQ.aluResult;
    assign retire       = memWbValid && !halted;
    assign regWriteIdx  = memWbQ.ctrl.dest;
    assign regWriteData = wbValue;
    assign regWriteEn   = retire && memWbQ.ctrl.regWrite;
    assign outputPort   = memWbQ.aluResult;
    assign outputValid  = retire && memWbQ.ctrl.isWwd;

    always_ff @(posedge Clk) begin
        if (reset) begin
            instCount <= '0;
            halted    <= 1'b0;
        end else if (retire) begin
            instCount <= instCount + 16'd1;
            if (memWbQ.ctrl.isHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

// File: design/cpuTop.sv
`timescale 1ns/100ps

module cpuTop #(
    parameter isaPkg::wordT ResetPc = '0
) (
    input  logic         Clk,
    input  logic         reset,
    output isaPkg::wordT instAddr,
    input  isaPkg::wordT instData,
    output isaPkg::wordT dataAddr,
    output isaPkg::wordT dataWdata,
    input  isaPkg::wordT dataRdata,
    output logic         dataRead,
    output logic         dataWrite,
    output isaPkg::wordT outputPort,
    output logic         outputValid,
    output isaPkg::wordT instCount,
    output logic         halted
);

    pipePkg::ifIdT   ifIdIn;
    pipePkg::ifIdT   ifIdQ;
    pipePkg::idExT   idExIn;
    pipePkg::idExT   idExQ;
    pipePkg::exMemT  exMemIn;
    pipePkg::exMemT  exMemQ;
    pipePkg::memWbT  memWbIn;
    pipePkg::memWbT  memWbQ;
    logic            fetchValid;
    logic            ifIdValid;
    logic            idExValid;
    logic            exMemValid;
    logic            memWbValid;
    pipePkg::ctrlT   idCtrl;
    logic            stallFetch;
    logic            bubbleEx;
    logic            flushIfId;
    logic            flushIdEx;
    logic            jumpTaken;
    pipePkg::fwdSelT fwdA;
    pipePkg::fwdSelT fwdB;
    isaPkg::wordT    aluA;
    isaPkg::wordT    aluB;
    isaPkg::aluOpT   aluOp;
    isaPkg::opcodeT  aluOpcode;
    isaPkg::wordT    aluResult;
    logic            branchTaken;
    isaPkg::regIdxT  regReadA;
    isaPkg::regIdxT  regReadB;
    isaPkg::wordT    regDataA;
    isaPkg::wordT    regDataB;
    isaPkg::regIdxT  regWriteIdx;
    isaPkg::wordT    regWriteData;
    logic            regWriteEn;

    pipelineControl ctrlUnit (
        .Clk        (Clk),
        .reset      (reset),
        .idInst     (ifIdQ.inst),
        .idValid    (ifIdValid),
        .exStage    (idExQ),
        .exValid    (idExValid),
        .memStage   (exMemQ),
        .memValid   (exMemValid),
        .wbStage    (memWbQ),
        .wbValid    (memWbValid),
        .branchTaken(branchTaken),
        .idCtrl     (idCtrl),
        .stallFetch (stallFetch),
        .bubbleEx   (bubbleEx),
        .flushIfId  (flushIfId),
        .flushIdEx  (flushIdEx),
        .jumpTaken  (jumpTaken),
        .fwdA       (fwdA),
        .fwdB       (fwdB)
    );

    // every datapath port shares its name with a wire or port here
    datapath #(.ResetPc(ResetPc)) dpath (.*);

    regFile regs (
        .Clk      (Clk),
        .reset    (reset),
        .readA    (regReadA),
        .readB    (regReadB),
        .writeIdx (regWriteIdx),
        .writeData(regWriteData),
        .writeEn  (regWriteEn),
        .dataA    (regDataA),
        .dataB    (regDataB)
    );

    alu aluUnit (
        .a          (aluA),
        .b          (aluB),
        .op         (aluOp),
        .opcode     (aluOpcode),
        .result     (aluResult),
        .branchTaken(branchTaken)
    );

    pipeStage #(.payloadT(pipePkg::ifIdT)) ifIdStage (
        .Clk     (Clk),
        .reset   (reset),
        .hold    (stallFetch),
        .bubble  (flushIfId),
        .inValid (fetchValid),
        .inData  (ifIdIn),
        .outValid(ifIdValid),
        .outData (ifIdQ)
    );

    pipeStage #(.payloadT(pipePkg::idExT)) idExStage (
        .Clk     (Clk),
        .reset   (reset),
        .hold    (1'b0),
        .bubble  (bubbleEx | flushIdEx),
        .inValid (ifIdValid),
        .inData  (idExIn),
        .outValid(idExValid),
        .outData (idExQ)
    );

    pipeStage #(.payloadT(pipePkg::exMemT)) exMemStage (
        .Clk     (Clk),
        .reset   (reset),
        .hold    (1'b0),
        .bubble  (1'b0),
        .inValid (idExValid),
        .inData  (exMemIn),
        .outValid(exMemValid),
        .outData (exMemQ)
    );

    pipeStage #(.payloadT(pipePkg::memWbT)) memWbStage (
        .Clk     (Clk),
        .reset   (reset),
        .hold    (1'b0),
        .bubble  (1'b0),
        .inValid (exMemValid),
        .inData  (memWbIn),
        .outValid(memWbValid),
        .outData (memWbQ)
    );

endmodule

// File: verification/tbClock.sv
`timescale 1ns/100ps

module tbClock #(
    parameter real Period      = 4.0,
    parameter int  ResetCycles = 3
) (
    output logic Clk,
    output logic reset
);

    initial begin
        Clk = 1'b0;
        forever begin
            #(Period / 2.0) Clk = ~Clk;
        end
    end

    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge Clk);
        reset <= 1'b0;
    end

endmodule

// File: verification/cpuTop_properties.sv
`timescale 1ns/100ps

module cpuTop_properties (
    input logic Clk,
    input logic reset,
    input logic dataRead,
    input logic dataWrite,
    input logic outputValid,
    input logic halted
);

    int failures = 0;

    // one memory strobe at a time
    assert property (@(posedge Clk) disable iff (reset) !(dataRead && dataWrite))
        else begin
            failures++;
            $error("dataRead and dataWrite are high in the same cycle");
        end

    // halted is sticky until the next reset
    assert property (@(posedge Clk) $fell(halted) |-> $past(reset))
        else begin
            failures++;
            $error("halted fell without a reset");
        end

    assert property (@(posedge Clk) disable iff (reset)
        halted |-> !dataRead && !dataWrite && !outputValid)
        else begin
            failures++;
            $error("memory strobe or outputValid seen while halted");
        end

endmodule

bind cpuTop cpuTop_properties props (
    .Clk        (Clk),
    .reset      (reset),
    .dataRead   (dataRead),
    .dataWrite  (dataWrite),
    .outputValid(outputValid),
    .halted     (halted)
);

// File: verification/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

    localparam isaPkg::wordT ResetPc       = 16'h0020;
    localparam int           ProgramCount  = 8;
    localparam int           ProgramLength = 40;
    localparam int           TimeoutCycles = 500;

    logic         Clk;
    logic         initReset;
    logic         restartReset;
    logic         reset;
    isaPkg::wordT instAddr;
    isaPkg::wordT instData;
    isaPkg::wordT dataAddr;
    isaPkg::wordT dataWdata;
    isaPkg::wordT dataRdata;
    logic         dataRead;
    logic         dataWrite;
    isaPkg::wordT outputPort;
    logic         outputValid;
    isaPkg::wordT instCount;
    logic         halted;

    isaPkg::wordT instMem [256];
    isaPkg::wordT dataMem [256];
    isaPkg::wordT modelMem [256];
    isaPkg::wordT modelRegs [4];
    isaPkg::wordT expectedWwd [$];
    int           modelCount;
    logic [31:0]  rngState;
    int           valueErrors;
    int           otherErrors;
    logic         aborted;

    tbClock #(.Period(4.0), .ResetCycles(3)) clockGen (
        .Clk  (Clk),
        .reset(initReset)
    );

    assign reset = initReset || restartReset;

    cpuTop #(.ResetPc(ResetPc)) UUT (
        .Clk        (Clk),
        .reset      (reset),
        .instAddr   (instAddr),
        .instData   (instData),
        .dataAddr   (dataAddr),
        .dataWdata  (dataWdata),
        .dataRdata  (dataRdata),
        .dataRead   (dataRead),
        .dataWrite  (dataWrite),
        .outputPort (outputPort),
        .outputValid(outputValid),
        .instCount  (instCount),
        .halted     (halted)
    );

    // both memories answer in the same cycle
    assign instData  = instMem[instAddr[7:0]];
    // without dataRead the data memory returns the inverted word
    assign dataRdata = dataRead ? dataMem[dataAddr[7:0]] : ~dataMem[dataAddr[7:0]];

    always @(posedge Clk) begin
        if (dataWrite) begin
            dataMem[dataAddr[7:0]] <= dataWdata;
        end
    end

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic checkValue(input string name, input isaPkg::wordT got,
                              input isaPkg::wordT expected);
        assert (got == expected) else begin
            valueErrors++;
            $display("FAIL %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic loadMemories(input logic [7:0] seed);
        isaPkg::wordT fill;
        for (int a = 0; a < 256; a++) begin
            fill        = {8'(a) ^ seed, 8'(a) + 8'h5b};
            instMem[a]  = {8'(a), ~8'(a)};
            dataMem[a]  = fill;
            modelMem[a] = fill;
        end
    endtask

    task automatic buildProgram();
        logic [31:0]    r;
        isaPkg::regIdxT rs;
        isaPkg::regIdxT rt;
        isaPkg::regIdxT rd;
        logic [7:0]     offset;
        int             i;
        int             addr;
        i = 0;
        while (i < ProgramLength - 1) begin
            r      = nextRandom();
            rs     = r[9:8];
            rt     = r[11:10];
            rd     = r[13:12];
            // forward targets never pass the closing HLT
            offset = 8'(r[18:16] % (ProgramLength - 1 - i));
            addr   = ResetPc + i;
            case (r[3:0])
                4'd0, 4'd1, 4'd2, 4'd3: begin
                    instMem[addr] = {isaPkg::OP_RTYPE, rs, rt, rd, 3'd0, r[6:4]};
                end
                4'd5: instMem[addr] = {isaPkg::OP_ORI, rs, rt, r[23:16]};
                4'd6: instMem[addr] = {isaPkg::OP_LHI, rs, rt, r[23:16]};
                4'd7, 4'd8: begin
                    instMem[addr] = {isaPkg::OP_LWD, rs, rt, r[23:16]};
                    if (i < ProgramLength - 2) begin
                        i++;
                        // the loaded register is consumed right away
                        instMem[ResetPc + i] = r[24] ?
                            {isaPkg::OP_RTYPE, rt, 4'd0, isaPkg::FN_WWD} :
                            {isaPkg::OP_RTYPE, rt, rs, rd, isaPkg::FN_ADD};
                    end
                end
                4'd9: instMem[addr] = {isaPkg::OP_SWD, rs, rt, r[23:16]};
                4'd10, 4'd11: instMem[addr] = {isaPkg::OP_RTYPE, rs, 4'd0, isaPkg::FN_WWD};
                4'd12, 4'd13: instMem[addr] = {2'b00, r[5:4], rs, rt, offset};
                4'd14: instMem[addr] = {isaPkg::OP_JMP, 12'(ResetPc + i + 1 + offset)};
                default: instMem[addr] = {isaPkg::OP_ADI, rs, rt, r[23:16]};
            endcase
            i++;
        end
        instMem[ResetPc + ProgramLength - 1] = {isaPkg::OP_RTYPE, 6'd0, isaPkg::FN_HLT};
    endtask

    // sequential reference of the ISA
    task automatic runModel();
        isaPkg::wordT   pc;
        isaPkg::wordT   inst;
        isaPkg::wordT   simm;
        isaPkg::wordT   ea;
        isaPkg::wordT   a;
        isaPkg::wordT   b;
        isaPkg::regIdxT rt;
        isaPkg::regIdxT rd;
        logic           done;
        int             steps;
        pc         = ResetPc;
        done       = 1'b0;
        steps      = 0;
        modelCount = 0;
        expectedWwd.delete();
        for (int k = 0; k < 4; k++) begin
            modelRegs[k] = '0;
        end
        while (!done && steps < 1000) begin
            inst = instMem[pc[7:0]];
            a    = modelRegs[inst[11:10]];
            b    = modelRegs[inst[9:8]];
            rt   = inst[9:8];
            rd   = inst[7:6];
            simm = {{8{inst[7]}}, inst[7:0]};
            ea   = a + simm;
            pc   = pc + 16'd1;
            modelCount++;
            steps++;
            case (isaPkg::opcodeT'(inst[15:12]))
                isaPkg::OP_BNE: if (a != b) pc = pc + simm;
                isaPkg::OP_BEQ: if (a == b) pc = pc + simm;
                isaPkg::OP_BGZ: if ($signed(a) > 0) pc = pc + simm;
                isaPkg::OP_BLZ: if ($signed(a) < 0) pc = pc + simm;
                isaPkg::OP_ADI: modelRegs[rt] = ea;
                isaPkg::OP_ORI: modelRegs[rt] = a | {8'd0, inst[7:0]};
                isaPkg::OP_LHI: modelRegs[rt] = {inst[7:0], 8'd0};
                isaPkg::OP_LWD: modelRegs[rt] = modelMem[ea[7:0]];
                isaPkg::OP_SWD: modelMem[ea[7:0]] = b;
                isaPkg::OP_JMP: pc = {pc[15:12], inst[11:0]};
                default: begin
                    case (isaPkg::funcT'(inst[5:0]))
                        isaPkg::FN_ADD: modelRegs[rd] = a + b;
                        isaPkg::FN_SUB: modelRegs[rd] = a - b;
                        isaPkg::FN_AND: modelRegs[rd] = a & b;
                        isaPkg::FN_ORR: modelRegs[rd] = a | b;
                        isaPkg::FN_NOT: modelRegs[rd] = ~a;
                        isaPkg::FN_TCP: modelRegs[rd] = 16'd0 - a;
                        isaPkg::FN_SHL: modelRegs[rd] = {a[14:0], 1'b0};
                        isaPkg::FN_SHR: modelRegs[rd] = {a[15], a[15:1]};
                        isaPkg::FN_WWD: expectedWwd.push_back(a);
                        isaPkg::FN_HLT: done = 1'b1;
                        default: ;
                    endcase
                end
            endcase
        end
    endtask

    task automatic waitResetRelease();
        int cycles;
        cycles = 0;
        do begin
            @(negedge Clk);
            cycles++;
        end while (reset && cycles < TimeoutCycles);
        assert (!reset) else begin
            otherErrors++;
            aborted = 1'b1;
            $display("timeout: reset stayed high for %0d cycles", TimeoutCycles);
        end
    endtask

    task automatic waitForHalt();
        int cycles;
        cycles = 0;
        while (!halted && cycles < TimeoutCycles) begin
            @(negedge Clk);
            cycles++;
        end
        assert (halted) else begin
            otherErrors++;
            aborted = 1'b1;
            $display("timeout: the core did not halt within %0d cycles", TimeoutCycles);
        end
    endtask

    // each WWD pulse must carry the next value of the model
    always @(negedge Clk) begin
        if (outputValid) begin
            assert (expectedWwd.size() > 0) else begin
                otherErrors++;
                $display("outputValid pulsed with no WWD value left in the model");
            end
            if (expectedWwd.size() > 0) begin
                checkValue("outputPort", outputPort, expectedWwd.pop_front());
            end
        end
    end

    initial begin
        restartReset <= 1'b0;
        rngState    = 32'd87596;
        valueErrors = 0;
        otherErrors = 0;
        aborted     = 1'b0;
        loadMemories(8'd0);
        for (int p = 0; p < ProgramCount && !aborted; p++) begin
            @(posedge Clk);
            restartReset <= 1'b1;
            @(negedge Clk);
            loadMemories(8'(p * 29));
            buildProgram();
            runModel();
            repeat (2) @(posedge Clk);
            restartReset <= 1'b0;
            waitResetRelease();
            if (!aborted) begin
                checkValue("halted", halted, 16'd0);
                checkValue("outputValid", outputValid, 16'd0);
                checkValue("dataRead", dataRead, 16'd0);
                checkValue("dataWrite", dataWrite, 16'd0);
                checkValue("instCount", instCount, 16'd0);
                checkValue("instAddr", instAddr, ResetPc);
                waitForHalt();
            end
            if (!aborted) begin
                checkValue("instCount", instCount, 16'(modelCount));
                // a short quiet window lets the monitor catch any late WWD
                repeat (4) @(negedge Clk);
                assert (expectedWwd.size() == 0) else begin
                    otherErrors++;
                    $display("%0d WWD values never appeared on outputPort",
                             expectedWwd.size());
                end
                for (int a = 0; a < 256; a++) begin
                    checkValue($sformatf("dataMem[%02h]", a), dataMem[a], modelMem[a]);
                end
            end
        end
        $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
                 valueErrors, otherErrors, UUT.props.failures);
        if (valueErrors == 0 && otherErrors == 0 && UUT.props.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: cpuTop.f
common/isaPkg.sv
common/pipePkg.sv
core/pipeStage.sv
core/regFile.sv
core/alu.sv
core/pipelineControl.sv
core/datapath.sv
design/cpuTop.sv
verification/tbClock.sv
verification/cpuTop_properties.sv
verification/cpuTb.sv
